/* hdl/fir_defines.svh */
`ifndef FIR_DEFINES_SVH
`define FIR_DEFINES_SVH

// filter length and coefficient banks per axis
`define FIR_TAPS 8
`define FIR_BANKS 4

// sample and output width, signed
`define SAMPLE_W 16

// Q1.16 coefficients, 17'h10000 is 1.0
`define COEFF_W 17

// wide enough for FIR_TAPS full-scale products
`define ACC_W 40

// drops the Q1.16 fraction from the sum
`define OUT_SHIFT 16

`endif

/* hdl/fir_pkg.sv */
`default_nettype none

`include "fir_defines.svh"

package fir_pkg;

        typedef logic signed [`SAMPLE_W-1:0] sample_t;

        // unsigned Q1.16, range 0 to just under 2.0
        typedef logic [`COEFF_W-1:0] coeff_t;

        typedef coeff_t [`FIR_TAPS-1:0] coeff_set_t;    // index 0 is tap 0

        typedef struct packed {
                sample_t x;
                sample_t y;
                sample_t z;
        } xyz_t;

        typedef struct packed {
                logic [$clog2(`FIR_BANKS)-1:0] x;
                logic [$clog2(`FIR_BANKS)-1:0] y;
                logic [$clog2(`FIR_BANKS)-1:0] z;
        } bank_sel_t;

        typedef enum logic [1:0] {
                none = 2'd0,    // write ignored
                x = 2'd1,
                y = 2'd2,
                z = 2'd3
        } axis_t;

        typedef struct packed {
                logic en;
                axis_t axis;
                logic [$clog2(`FIR_BANKS)-1:0] bank;
                logic [$clog2(`FIR_TAPS)-1:0] index;
                coeff_t value;
        } coeff_wr_t;

        typedef enum logic [1:0] {
                idle,
                filter_setup,
                filter,
                hold
        } seq_state_t;

endpackage

`default_nettype wire

/* hdl/coeff_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fir_defines.svh"

module coeff_bank (
        input logic sys_clk,
        input logic rst_n,
        input fir_pkg::coeff_wr_t coeff_wr,
        input fir_pkg::bank_sel_t bank_sel,
        output fir_pkg::coeff_set_t x_coeffs,
        output fir_pkg::coeff_set_t y_coeffs,
        output fir_pkg::coeff_set_t z_coeffs
);

        // [axis][bank], axis 0 is x
        fir_pkg::coeff_set_t mem [3][`FIR_BANKS];

        logic wr_hit;
        logic [1:0] wr_axis;

        // power-up contents, identical for all three axes
        function automatic fir_pkg::coeff_set_t reset_set(input int bank);
                fir_pkg::coeff_set_t set;
                set = '0;
                for (int k = 0; k < `FIR_TAPS; k++) begin
                        case (bank)
                                0: begin
                                        if (k == 0)
                                                set[k] = 17'h10000;     // identity
                                end
                                1: begin
                                        set[k] = 17'h2000;      // 8-sample mean
                                end
                                2: begin
                                        if (k >= 2 && k <= 5)
                                                set[k] = 17'h4000;      // delayed 4-sample mean
                                end
                                default: begin
                                        set[k] = '0;
                                end
                        endcase
                end
                return set;
        endfunction

        assign wr_hit = coeff_wr.en && (coeff_wr.axis != fir_pkg::none);
        assign wr_axis = 2'(coeff_wr.axis) - 2'd1;      // x..z onto 0..2

        always_ff @(posedge sys_clk or negedge rst_n) begin
                if (!rst_n) begin
                        for (int a = 0; a < 3; a++) begin
                                for (int b = 0; b < `FIR_BANKS; b++) begin
                                        mem[a][b] <= reset_set(b);
                                end
                        end
                end else if (wr_hit) begin
                        mem[wr_axis][coeff_wr.bank][coeff_wr.index] <= coeff_wr.value;
                end
        end

        assign x_coeffs = mem[0][bank_sel.x];
        assign y_coeffs = mem[1][bank_sel.y];
        assign z_coeffs = mem[2][bank_sel.z];

endmodule

`default_nettype wire

/* hdl/fir_mac.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fir_defines.svh"

module fir_mac (
        input logic sys_clk,
        input logic rst_n,
        input logic start,
        input fir_pkg::sample_t sample,
        input fir_pkg::coeff_set_t coeffs,
        output logic busy,
        output fir_pkg::sample_t result
);

        localparam int STEP_W = $clog2(`FIR_TAPS) + 1;

        fir_pkg::sample_t [`FIR_TAPS-1:0] hist;         // hist[0] is newest
        fir_pkg::coeff_set_t coeff_q;
        logic [STEP_W-1:0] step;
        logic [STEP_W-2:0] tap;
        logic last;
        logic signed [`SAMPLE_W+`COEFF_W:0] product;
        logic signed [`ACC_W-1:0] acc;
        logic signed [`ACC_W-1:0] acc_shifted;

        assign tap = step[STEP_W-2:0];
        assign last = (step == STEP_W'(`FIR_TAPS));

        // coefficient zero-extended so 17'h10000 stays +1.0
        assign product = $signed(hist[tap]) * $signed({1'b0, coeff_q[tap]});
        assign acc_shifted = acc >>> `OUT_SHIFT;

        always_ff @(posedge sys_clk or negedge rst_n) begin
                if (!rst_n) begin
                        hist <= '0;
                        busy <= 1'b0;
                        step <= '0;
                        result <= '0;
                end else if (start) begin
                        hist <= {hist[`FIR_TAPS-2:0], sample};
                        busy <= 1'b1;
                        step <= '0;
                end else if (busy) begin
                        if (last) begin
                                result <= acc_shifted[`SAMPLE_W-1:0];
                                busy <= 1'b0;
                        end else begin
                                step <= step + 1'b1;
                        end
                end
        end

        // bank snapshot taken with the run start
        always_ff @(posedge sys_clk) begin
                if (start) begin
                        coeff_q <= coeffs;
                        acc <= '0;
                end else if (busy && !last) begin
                        acc <= acc + product;
                end
        end

endmodule

`default_nettype wire

/* hdl/sample_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_sequencer (
        input logic sys_clk,
        input logic rst_n,
        input logic sample_valid,
        input fir_pkg::xyz_t sample_in,
        input logic [2:0] fir_busy,
        output logic fir_start,
        output fir_pkg::xyz_t fir_sample,
        output logic available,
        output logic data_interrupt
);

        fir_pkg::seq_state_t state;
        logic accept;

        // available is only high in idle and hold
        assign accept = sample_valid && available;
        assign fir_start = (state == fir_pkg::filter_setup);

        always_ff @(posedge sys_clk or negedge rst_n) begin
                if (!rst_n) begin
                        state <= fir_pkg::idle;
                        available <= 1'b1;
                        data_interrupt <= 1'b0;
                end else begin
                        data_interrupt <= (state == fir_pkg::hold);     // one cycle
                        case (state)
                                fir_pkg::idle, fir_pkg::hold: begin
                                        if (accept) begin
                                                state <= fir_pkg::filter_setup;
                                                available <= 1'b0;
                                        end else begin
                                                state <= fir_pkg::idle;
                                        end
                                end
                                fir_pkg::filter_setup: begin
                                        state <= fir_pkg::filter;
                                end
                                fir_pkg::filter: begin
                                        if (fir_busy == 3'b000) begin   // all axes done
                                                state <= fir_pkg::hold;
                                                available <= 1'b1;
                                        end
                                end
                                default: begin
                                        state <= fir_pkg::idle;
                                end
                        endcase
                end
        end

        always_ff @(posedge sys_clk) begin
                if (accept)
                        fir_sample <= sample_in;
        end

endmodule

`default_nettype wire

/* hdl/accel_filter_top.sv */
`timescale 1ns/1ps
`default_nettype none

module accel_filter_top (
        input logic sys_clk,
        input logic rst_n,
        input logic sample_valid,
        input fir_pkg::xyz_t sample_in,
        input fir_pkg::bank_sel_t bank_sel,
        input fir_pkg::coeff_wr_t coeff_wr,
        output fir_pkg::xyz_t filt_out,
        output logic available,
        output logic data_interrupt
);

        logic fir_start;
        logic [2:0] fir_busy;   // x, y, z in bits 0..2
        fir_pkg::xyz_t fir_sample;
        fir_pkg::coeff_set_t x_coeffs;
        fir_pkg::coeff_set_t y_coeffs;
        fir_pkg::coeff_set_t z_coeffs;

        sample_sequencer seq_i (
                .sys_clk(sys_clk),
                .rst_n(rst_n),
                .sample_valid(sample_valid),
                .sample_in(sample_in),
                .fir_busy(fir_busy),
                .fir_start(fir_start),
                .fir_sample(fir_sample),
                .available(available),
                .data_interrupt(data_interrupt)
        );

        coeff_bank coeff_i (
                .sys_clk(sys_clk),
                .rst_n(rst_n),
                .coeff_wr(coeff_wr),
                .bank_sel(bank_sel),
                .x_coeffs(x_coeffs),
                .y_coeffs(y_coeffs),
                .z_coeffs(z_coeffs)
        );

        fir_mac fir_x (
                .sys_clk(sys_clk),
                .rst_n(rst_n),
                .start(fir_start),
                .sample(fir_sample.x),
                .coeffs(x_coeffs),
                .busy(fir_busy[0]),
                .result(filt_out.x)
        );

        fir_mac fir_y (
                .sys_clk(sys_clk),
                .rst_n(rst_n),
                .start(fir_start),
                .sample(fir_sample.y),
                .coeffs(y_coeffs),
                .busy(fir_busy[1]),
                .result(filt_out.y)
        );

        fir_mac fir_z (
                .sys_clk(sys_clk),
                .rst_n(rst_n),
                .start(fir_start),
                .sample(fir_sample.z),
                .coeffs(z_coeffs),
                .busy(fir_busy[2]),
                .result(filt_out.z)
        );

endmodule

`default_nettype wire

/* sim/clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
        output logic sys_clk
);

        initial begin
                sys_clk = 1'b0;
                forever #2 sys_clk = ~sys_clk;  // 4 ns period
        end

endmodule

`default_nettype wire

/* sim/tb_accel_filter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fir_defines.svh"

module tb_accel_filter;

        typedef struct packed {
                logic is_write;
                fir_pkg::coeff_wr_t wr;
                fir_pkg::xyz_t smp;
                fir_pkg::bank_sel_t sel;
                fir_pkg::xyz_t expect_out;
        } rec_t;

        logic sys_clk;
        logic rst_n;
        logic sample_valid;
        fir_pkg::xyz_t sample_in;
        fir_pkg::bank_sel_t bank_sel;
        fir_pkg::coeff_wr_t coeff_wr;
        fir_pkg::xyz_t filt_out;
        logic available;
        logic data_interrupt;

        rec_t recs[$];
        int value_errors = 0;
        int format_errors = 0;
        int checks_run = 0;
        int unsigned cycle_count = 0;
        int unsigned cycle_limit = 0;   // set once the records are known

        clk_gen clk_i (.sys_clk(sys_clk));

        accel_filter_top accel_filter_top_i (
                .sys_clk(sys_clk),
                .rst_n(rst_n),
                .sample_valid(sample_valid),
                .sample_in(sample_in),
                .bank_sel(bank_sel),
                .coeff_wr(coeff_wr),
                .filt_out(filt_out),
                .available(available),
                .data_interrupt(data_interrupt)
        );

        task automatic check_value(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
                checks_run++;
                assert (actual === expected) else begin
                        value_errors++;
                        $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
                end
        endtask

        task automatic load_golden();
                int fd;
                int n;
                int line_no;
                int axis_v, bank_v, index_v, bx, by, bz;
                logic [8*160-1:0] line_buf;
                logic [8*8-1:0] tag;
                logic [`COEFF_W-1:0] value_v;
                logic [15:0] sx, sy, sz, ex, ey, ez;
                rec_t r;
                fd = $fopen("sim/accel_filter_golden.txt", "r");
                if (fd == 0) begin
                        format_errors++;
                        $display("could not open sim/accel_filter_golden.txt");
                end else begin
                        line_no = 0;
                        line_buf = '0;
                        while ($fgets(line_buf, fd) != 0) begin
                                line_no++;
                                tag = '0;
                                r = '0;
                                n = $sscanf(line_buf, "%s", tag);
                                if (tag == "W") begin
                                        n = $sscanf(line_buf, "%s %d %d %d %h", tag,
                                                    axis_v, bank_v, index_v, value_v);
                                        r.is_write = 1'b1;
                                        r.wr.en = 1'b1;
                                        r.wr.axis = fir_pkg::axis_t'(axis_v[1:0]);
                                        r.wr.bank = bank_v[1:0];
                                        r.wr.index = index_v[2:0];
                                        r.wr.value = value_v;
                                        if (n == 5)
                                                recs.push_back(r);
                                        else begin
                                                format_errors++;
                                                $display("golden line %0d is a broken write record",
                                                         line_no);
                                        end
                                end else if (tag == "S") begin
                                        n = $sscanf(line_buf, "%s %h %h %h %d %d %d %h %h %h", tag,
                                                    sx, sy, sz, bx, by, bz, ex, ey, ez);
                                        r.smp = '{x: sx, y: sy, z: sz};
                                        r.sel = '{x: bx[1:0], y: by[1:0], z: bz[1:0]};
                                        r.expect_out = '{x: ex, y: ey, z: ez};
                                        if (n == 10)
                                                recs.push_back(r);
                                        else begin
                                                format_errors++;
                                                $display("golden line %0d is a broken sample record",
                                                         line_no);
                                        end
                                end
                                line_buf = '0;
                        end
                        $fclose(fd);
                        if (recs.size() == 0) begin
                                format_errors++;
                                $display("golden file holds no records");
                        end
                end
        endtask

        task automatic apply_write(input rec_t r);
                @(posedge sys_clk);
                coeff_wr <= r.wr;
                @(posedge sys_clk);
                coeff_wr <= '0;
        endtask

        task automatic run_sample(input rec_t r, input int num);
                string name;
                int k;
                logic seen;
                name = $sformatf("S%0d", num);
                @(posedge sys_clk);
                sample_in <= r.smp;
                bank_sel <= r.sel;
                sample_valid <= 1'b1;
                @(negedge sys_clk);
                while (!available)
                        @(negedge sys_clk);
                @(posedge sys_clk);     // accept edge
                sample_valid <= 1'b0;
                k = 0;
                seen = 1'b0;
                while (!seen) begin
                        @(posedge sys_clk);
                        k++;
                        if (k == 2) begin       // decoy while busy
                                sample_in <= ~r.smp;
                                sample_valid <= 1'b1;
                        end
                        if (k == 5)
                                sample_valid <= 1'b0;
                        @(negedge sys_clk);
                        if (data_interrupt)
                                seen = 1'b1;
                        else if (k < `FIR_TAPS + 3)
                                check_value({name, " available during run"}, 0, available);
                end
                check_value({name, " interrupt latency"}, `FIR_TAPS + 4, k);
                check_value({name, " filt_out.x"}, $unsigned(r.expect_out.x), $unsigned(filt_out.x));
                check_value({name, " filt_out.y"}, $unsigned(r.expect_out.y), $unsigned(filt_out.y));
                check_value({name, " filt_out.z"}, $unsigned(r.expect_out.z), $unsigned(filt_out.z));
                @(negedge sys_clk);
                check_value({name, " interrupt width"}, 0, data_interrupt);
        endtask

        always @(posedge sys_clk) begin
                cycle_count <= cycle_count + 1;
                if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
                        $display("run timed out after %0d cycles, records not finished",
                                 cycle_count);
                        $display("Regression failed");
                        $finish;
                end
        end

        initial begin
                int num;
                rst_n = 1'b0;
                sample_valid = 1'b0;
                sample_in = '0;
                bank_sel = '0;
                coeff_wr = '0;
                load_golden();
                cycle_limit = recs.size() * (`FIR_TAPS + 20) + 100;
                repeat (5) @(posedge sys_clk);
                rst_n <= 1'b1;
                @(negedge sys_clk);
                check_value("reset available", 1, available);
                check_value("reset data_interrupt", 0, data_interrupt);
                check_value("reset filt_out.x", 0, $unsigned(filt_out.x));
                check_value("reset filt_out.y", 0, $unsigned(filt_out.y));
                check_value("reset filt_out.z", 0, $unsigned(filt_out.z));
                num = 0;
                foreach (recs[i]) begin
                        if (recs[i].is_write)
                                apply_write(recs[i]);
                        else begin
                                num++;
                                run_sample(recs[i], num);
                        end
                end
                $display("checks %0d, value errors %0d, format errors %0d",
                         checks_run, value_errors, format_errors);
                if (value_errors == 0 && format_errors == 0) begin
                        $display("Regression passed");
                end else begin
                        $display("Regression failed");
                end
                $finish;
        end

endmodule

`default_nettype wire

/* project.f */
+incdir+hdl
hdl/fir_pkg.sv
hdl/coeff_bank.sv
hdl/fir_mac.sv
hdl/sample_sequencer.sv
hdl/accel_filter_top.sv
sim/clk_gen.sv
sim/tb_accel_filter.sv

/* sim/accel_filter_golden.txt */
# W axis bank index value    (axis 0 none 1 x 2 y 3 z, value 17-bit hex)
# S x y z bank_x bank_y bank_z exp_x exp_y exp_z    (samples and results 16-bit hex)
# identity bank on every axis
S 0100 ff00 1234 0 0 0 0100 ff00 1234
S 0200 fe00 7fff 0 0 0 0200 fe00 7fff
S 0300 fd00 8000 0 0 0 0300 fd00 8000
# mean, delayed 4-tap sum and zero bank on different axes
S 0400 fc00 0010 1 2 3 0140 ff40 0000
S 0500 fb00 0020 2 3 1 0180 0000 024c
S 0600 fa00 0030 3 1 2 0000 fd60 0490
# x bank 0 tap 0 set to 0.5
W 1 0 0 08000
# write to no axis is dropped
W 0 0 0 00000
# y bank 3 tap 1 set to 1.0
W 2 3 1 10000
S 0700 f900 0040 0 3 0 0380 fa00 0040
S 0800 f800 0050 3 0 3 0000 f800 0000
# negative mean rounds toward minus infinity
S 0003 fffd 0000 1 1 2 0460 fb9f 0028
